// ==== Makefile ====
TOP := tb_osd_config
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -q "^Simulation passed$$" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// ==== list.f ====
rtl/osd_pkg.sv
rtl/osd_status_regs.sv
rtl/osd_dip_decoder.sv
rtl/osd_config_top.sv
tb/tb_osd_config.sv

// ==== rtl/osd_config_top.sv ====
`timescale 1ns/1ns

module osd_config_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  osd_pkg::apb_req_t    apb_req,
    output osd_pkg::apb_rsp_t    apb_rsp,
    input  logic                 game_pause,
    input  logic                 game_test,
    output osd_pkg::video_cfg_t  video_cfg,
    output osd_pkg::audio_cfg_t  audio_cfg,
    output osd_pkg::game_dip_t   game_dip
);

    osd_pkg::status_t   status;    // full OSD word from the host
    osd_pkg::core_mod_t core_mod;

    // APB register bank
    osd_status_regs u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .status   (status),
        .core_mod (core_mod)
    );

    // one more edge to reach the outputs
    osd_dip_decoder u_dec (
        .clk        (clk),
        .rst_n      (rst_n),
        .status     (status),
        .core_mod   (core_mod),
        .game_pause (game_pause),
        .game_test  (game_test),
        .video_cfg  (video_cfg),
        .audio_cfg  (audio_cfg),
        .game_dip   (game_dip)
    );

endmodule

// ==== rtl/osd_dip_decoder.sv ====
`timescale 1ns/1ns

module osd_dip_decoder (
    input  logic                 clk,
    input  logic                 rst_n,
    input  osd_pkg::status_t     status,
    input  osd_pkg::core_mod_t   core_mod,
    input  logic                 game_pause,
    input  logic                 game_test,
    output osd_pkg::video_cfg_t  video_cfg,
    output osd_pkg::audio_cfg_t  audio_cfg,
    output osd_pkg::game_dip_t   game_dip
);

    logic                tate;       // vertical game (tate in Japanese)
    logic                rot_ctrl;
    logic                flip_n;     // active low flip switch
    logic [1:0]          ar;         // aspect ratio menu choice
    logic [1:0]          vmode;      // video mode menu choice
    osd_pkg::video_cfg_t video_nxt;
    osd_pkg::audio_cfg_t audio_nxt;
    osd_pkg::game_dip_t  dip_nxt;

    assign tate     = core_mod[0];
    assign rot_ctrl = status[2];
    assign flip_n   = ~status[1];
    assign ar       = status[17:16];
    assign vmode    = status[4:3];

    // video settings
    always_comb begin
        video_nxt = '0;

        // scanlines, bw, blend by mode
        case (vmode)
            2'd0: begin                     // pass-through
                video_nxt.scanlines = 3'd0;
                video_nxt.bw_en     = 1'b0;
                video_nxt.blend_en  = 1'b0;
            end
            2'd1: begin                     // linear interpolation
                video_nxt.scanlines = 3'd0;
                video_nxt.bw_en     = 1'b0;
                video_nxt.blend_en  = 1'b1;
            end
            2'd2: begin                     // analogue look
                video_nxt.scanlines = 3'd0;
                video_nxt.bw_en     = 1'b1;
                video_nxt.blend_en  = 1'b1;
            end
            default: begin                  // analogue plus scanlines
                video_nxt.scanlines = 3'd1;
                video_nxt.bw_en     = 1'b1;
                video_nxt.blend_en  = 1'b1;
            end
        endcase

        video_nxt.en_mixing   = ~status[3];
        video_nxt.rot_control = rot_ctrl;
        // upper bit is flip, lower bit turns the screen
        video_nxt.rotate      = {~flip_n, tate & ~rot_ctrl};

        // aspect ratio
        if (ar == 2'd0) begin
            if (tate) begin                 // vertical game, swap terms
                video_nxt.hdmi_arx = osd_pkg::ARY_DEFAULT;
                video_nxt.hdmi_ary = osd_pkg::ARX_DEFAULT;
            end else begin
                video_nxt.hdmi_arx = osd_pkg::ARX_DEFAULT;
                video_nxt.hdmi_ary = osd_pkg::ARY_DEFAULT;
            end
        end else begin
            // wide modes, HDMI side picks the ratio code
            video_nxt.hdmi_arx = osd_pkg::ar_t'(ar - 2'd1);
            video_nxt.hdmi_ary = '0;
        end
    end

    // audio
    always_comb begin
        audio_nxt.enable_fm  = ~status[9];
        audio_nxt.enable_psg = ~status[8];
        audio_nxt.fxlevel    = status[7:6] ^ 2'b10;  // menu order differs from level
    end

    // game switches, all active low
    always_comb begin
        dip_nxt.dip_pause = ~game_pause;
        dip_nxt.dip_test  = ~(status[10] | game_test);  // OSD or cabinet test button
        dip_nxt.dip_flip  = flip_n;
    end

    // every setting registered once
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            video_cfg <= '0;
            audio_cfg <= '0;
            game_dip  <= '0;
        end else begin
            video_cfg <= video_nxt;
            audio_cfg <= audio_nxt;
            game_dip  <= dip_nxt;
        end
    end

    // portrait ratio only with the screen or the controls turned
    a_portrait_is_tate: assert property (
        @(posedge clk) disable iff (!rst_n)
        (video_cfg.hdmi_ary == osd_pkg::ARX_DEFAULT)
            |-> (video_cfg.rotate[0] | video_cfg.rot_control)
    );

    // scanline mode shares bit 3 with the mixer switch
    a_scan_mutes_mix: assert property (
        @(posedge clk) disable iff (!rst_n)
        (video_cfg.scanlines != 3'd0) |-> !video_cfg.en_mixing
    );

endmodule

// ==== rtl/osd_pkg.sv ====
package osd_pkg;

    // widths that carry a meaning
    typedef logic [63:0] status_t;    // OSD status word from the menu controller
    typedef logic [6:0]  core_mod_t;  // core mode, bit 0 marks a vertical game
    typedef logic [11:0] ar_t;        // one HDMI aspect ratio term
    typedef logic [3:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // APB request from the host side
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    // APB response back to the host
    typedef struct packed {
        apb_data_t prdata;
        logic      pready;   // tied high, slave never stalls
        logic      pslverr;
    } apb_rsp_t;

    // video settings handed to the scaler and HDMI path
    typedef struct packed {
        ar_t        hdmi_arx;
        ar_t        hdmi_ary;
        logic [1:0] rotate;      // {flip, rotate 90}
        logic       rot_control; // rotate player controls instead of screen
        logic [2:0] scanlines;
        logic       bw_en;
        logic       blend_en;
        logic       en_mixing;
    } video_cfg_t;

    // audio settings
    typedef struct packed {
        logic       enable_fm;
        logic       enable_psg;
        logic [1:0] fxlevel;     // FX volume
    } audio_cfg_t;

    // game DIP switches, all active low like the original boards
    typedef struct packed {
        logic dip_pause;
        logic dip_test;
        logic dip_flip;
    } game_dip_t;

    // register map
    localparam apb_addr_t ADDR_STATUS_LO = 4'h0; // status[31:0]
    localparam apb_addr_t ADDR_STATUS_HI = 4'h4; // status[63:32]
    localparam apb_addr_t ADDR_CORE_MOD  = 4'h8; // core mode in bits 6:0

    // native 4:3 screen
    localparam ar_t ARX_DEFAULT = 12'd4;
    localparam ar_t ARY_DEFAULT = 12'd3;

endpackage

// ==== rtl/osd_status_regs.sv ====
`timescale 1ns/1ns

module osd_status_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  osd_pkg::apb_req_t   apb_req,
    output osd_pkg::apb_rsp_t   apb_rsp,
    output osd_pkg::status_t    status,
    output osd_pkg::core_mod_t  core_mod
);

    logic               access;     // access phase of a transfer
    logic               hit_lo;
    logic               hit_hi;
    logic               hit_mod;
    logic               addr_ok;    // address is one of the three mapped regs
    osd_pkg::apb_data_t rd_data;
    logic [31:0]        status_lo;
    logic [31:0]        status_hi;
    osd_pkg::core_mod_t core_mod_q;

    assign access  = apb_req.psel & apb_req.penable;
    assign hit_lo  = apb_req.paddr == osd_pkg::ADDR_STATUS_LO;
    assign hit_hi  = apb_req.paddr == osd_pkg::ADDR_STATUS_HI;
    assign hit_mod = apb_req.paddr == osd_pkg::ADDR_CORE_MOD;
    assign addr_ok = hit_lo | hit_hi | hit_mod;

    // register writes land on the access phase edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_lo  <= '0;
            status_hi  <= '0;
            core_mod_q <= '0;
        end else if (access && apb_req.pwrite) begin
            if (hit_lo) begin
                status_lo <= apb_req.pwdata;
            end
            if (hit_hi) begin
                status_hi <= apb_req.pwdata;
            end
            if (hit_mod) begin
                core_mod_q <= apb_req.pwdata[6:0]; // upper bits dropped
            end
        end
    end

    // readback mux, only driven during access
    always_comb begin
        rd_data = '0;
        if (access && !apb_req.pwrite) begin
            if (hit_lo) begin
                rd_data = status_lo;
            end else if (hit_hi) begin
                rd_data = status_hi;
            end else if (hit_mod) begin
                rd_data = {25'd0, core_mod_q};  // unused bits read zero
            end
        end
    end

    assign apb_rsp.prdata  = rd_data;
    assign apb_rsp.pready  = 1'b1;               // zero wait states
    assign apb_rsp.pslverr = access & ~addr_ok;  // unmapped address

    assign status   = {status_hi, status_lo};
    assign core_mod = core_mod_q;

    // access phase always comes right after a setup cycle
    a_access_after_setup: assert property (
        @(posedge clk) disable iff (!rst_n)
        (apb_req.psel && apb_req.penable) |-> $past(apb_req.psel && !apb_req.penable)
    );

    // unmapped access leaves every register alone
    a_err_keeps_regs: assert property (
        @(posedge clk) disable iff (!rst_n)
        apb_rsp.pslverr |=> ($stable(status) && $stable(core_mod))
    );

endmodule

// ==== tb/tb_osd_config.sv ====
`timescale 1ns/1ns

module tb_osd_config;

    localparam int TIMEOUT_CYCLES = 1500;  // tests take roughly 700 cycles

    logic                clk = 1'b0;
    logic                rst_n;
    osd_pkg::apb_req_t   apb_req;
    osd_pkg::apb_rsp_t   apb_rsp;
    logic                game_pause;
    logic                game_test;
    osd_pkg::video_cfg_t video_cfg;
    osd_pkg::audio_cfg_t audio_cfg;
    osd_pkg::game_dip_t  game_dip;

    osd_pkg::status_t    cur_status;       // shadow of what the host wrote
    osd_pkg::core_mod_t  cur_mod;
    integer              seed = 32'hf37a255d;
    int                  cycle_count = 0;

    osd_config_top u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .game_pause (game_pause),
        .game_test  (game_test),
        .video_cfg  (video_cfg),
        .audio_cfg  (audio_cfg),
        .game_dip   (game_dip)
    );

    always #20 clk = ~clk;  // 40 ns period

    // run limit
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            fail_run();
        end
    end

    task automatic fail_run();
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_video(input string name, input osd_pkg::video_cfg_t exp,
                               input osd_pkg::video_cfg_t act);
        if (act !== exp) begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_audio(input string name, input osd_pkg::audio_cfg_t exp,
                               input osd_pkg::audio_cfg_t act);
        if (act !== exp) begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_dip(input string name, input osd_pkg::game_dip_t exp,
                             input osd_pkg::game_dip_t act);
        if (act !== exp) begin
            $display("Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_data(input string name, input osd_pkg::apb_data_t exp,
                              input osd_pkg::apb_data_t act);
        if (act !== exp) begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
            fail_run();
        end
    endtask

    // setup then access, called and returning on a falling edge
    task automatic apb_write(input osd_pkg::apb_addr_t addr, input osd_pkg::apb_data_t data,
                             input logic exp_err);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(negedge clk);
        apb_req.penable = 1'b1;
        @(posedge clk);  // access seen here
        check_err("pslverr", exp_err, apb_rsp.pslverr);
        check_err("pready", 1'b1, apb_rsp.pready);  // no wait states
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic apb_read(input osd_pkg::apb_addr_t addr, input osd_pkg::apb_data_t exp_data,
                            input logic exp_err);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = addr;
        apb_req.pwdata  = '0;
        @(negedge clk);
        apb_req.penable = 1'b1;
        @(posedge clk);  // read data is stable through the access cycle
        check_data("prdata", exp_data, apb_rsp.prdata);
        check_err("pslverr", exp_err, apb_rsp.pslverr);
        check_err("pready", 1'b1, apb_rsp.pready);
        @(negedge clk);
        apb_req = '0;
    endtask

    // writes only the registers that differ from the shadow
    task automatic update_regs(input osd_pkg::status_t s, input osd_pkg::apb_data_t mod_word);
        if (s[31:0] != cur_status[31:0]) begin
            apb_write(osd_pkg::ADDR_STATUS_LO, s[31:0], 1'b0);
        end
        if (s[63:32] != cur_status[63:32]) begin
            apb_write(osd_pkg::ADDR_STATUS_HI, s[63:32], 1'b0);
        end
        if (mod_word[6:0] != cur_mod) begin
            apb_write(osd_pkg::ADDR_CORE_MOD, mod_word, 1'b0);
        end
        cur_status = s;
        cur_mod    = mod_word[6:0];
    endtask

    // expected settings straight from the decoding rules
    task automatic model_decode(input osd_pkg::status_t s, input osd_pkg::core_mod_t m,
                                input logic pause, input logic test,
                                output osd_pkg::video_cfg_t v, output osd_pkg::audio_cfg_t a,
                                output osd_pkg::game_dip_t d);
        logic [1:0] mode;
        logic [1:0] ar;
        logic       tate;
        mode = s[4:3];
        ar   = s[17:16];
        tate = m[0];
        v = '0;
        v.scanlines   = (mode == 2'd3) ? 3'd1 : 3'd0;
        v.bw_en       = mode[1];            // analogue modes
        v.blend_en    = (mode != 2'd0);
        v.en_mixing   = ~s[3];
        v.rot_control = s[2];
        d.dip_flip    = ~s[1];
        v.rotate[1]   = ~d.dip_flip;
        v.rotate[0]   = tate & ~s[2];
        if (ar == 2'd0) begin
            v.hdmi_arx = tate ? osd_pkg::ARY_DEFAULT : osd_pkg::ARX_DEFAULT;
            v.hdmi_ary = tate ? osd_pkg::ARX_DEFAULT : osd_pkg::ARY_DEFAULT;
        end else begin
            v.hdmi_arx = {10'd0, ar} - 12'd1;
            v.hdmi_ary = '0;
        end
        a.enable_fm   = ~s[9];
        a.enable_psg  = ~s[8];
        a.fxlevel     = s[7:6] ^ 2'b10;
        d.dip_test    = ~(s[10] | test);
        d.dip_pause   = ~pause;
    endtask

    task automatic check_all();
        osd_pkg::video_cfg_t ev;
        osd_pkg::audio_cfg_t ea;
        osd_pkg::game_dip_t  ed;
        model_decode(cur_status, cur_mod, game_pause, game_test, ev, ea, ed);
        check_video("video_cfg", ev, video_cfg);
        check_audio("audio_cfg", ea, audio_cfg);
        check_dip("game_dip", ed, game_dip);
    endtask

    // register edge already passed in the write, decoder edge next, then sample low
    task automatic wait_decode();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic test_reset_state();
        apb_read(osd_pkg::ADDR_STATUS_LO, 32'd0, 1'b0);
        apb_read(osd_pkg::ADDR_STATUS_HI, 32'd0, 1'b0);
        apb_read(osd_pkg::ADDR_CORE_MOD, 32'd0, 1'b0);
        wait_decode();
        check_all();
    endtask

    task automatic test_readback();
        osd_pkg::apb_addr_t bad_addr [4];
        bad_addr = '{4'h1, 4'h2, 4'hc, 4'hf};
        apb_write(osd_pkg::ADDR_STATUS_LO, 32'hdead_beef, 1'b0);
        apb_write(osd_pkg::ADDR_STATUS_HI, 32'h1357_9bdf, 1'b0);
        apb_write(osd_pkg::ADDR_CORE_MOD, 32'hffff_ff5a, 1'b0);  // only 7 bits kept
        cur_status = 64'h1357_9bdf_dead_beef;
        cur_mod    = 7'h5a;
        foreach (bad_addr[i]) begin
            apb_write(bad_addr[i], 32'h0bad_0bad, 1'b1);
            apb_read(bad_addr[i], 32'd0, 1'b1);
        end
        apb_read(osd_pkg::ADDR_STATUS_LO, 32'hdead_beef, 1'b0);
        apb_read(osd_pkg::ADDR_STATUS_HI, 32'h1357_9bdf, 1'b0);
        apb_read(osd_pkg::ADDR_CORE_MOD, 32'h0000_005a, 1'b0);
        wait_decode();
        check_all();
    endtask

    task automatic test_video_modes();
        osd_pkg::status_t s;
        update_regs('0, 32'd0);
        for (int mode = 0; mode < 4; mode++) begin
            s = '0;
            s[4:3] = mode[1:0];
            update_regs(s, 32'd0);
            wait_decode();
            check_all();
        end
    endtask

    task automatic test_aspect_rotation();
        osd_pkg::status_t s;
        for (int ar = 0; ar < 4; ar++) begin
            for (int combo = 0; combo < 8; combo++) begin  // {tate, rot_control, flip}
                s = '0;
                s[17:16] = ar[1:0];
                s[2]     = combo[1];
                s[1]     = combo[0];
                update_regs(s, {31'd0, combo[2]});
                wait_decode();
                check_all();
            end
        end
    endtask

    task automatic test_audio_switches();
        osd_pkg::status_t s;
        for (int i = 0; i < 16; i++) begin  // fm, psg and fxlevel bits 9:6
            s = '0;
            s[9:6] = i[3:0];
            update_regs(s, 32'd0);
            wait_decode();
            check_all();
        end
        for (int i = 0; i < 4; i++) begin   // test switch from OSD or cabinet
            s = '0;
            s[10] = i[1];
            update_regs(s, 32'd0);
            game_test = i[0];
            wait_decode();
            check_all();
        end
        game_test = 1'b0;
        update_regs('0, 32'd0);             // OSD test bit off so the cabinet button shows
        for (int i = 0; i < 6; i++) begin
            game_pause = ~game_pause;       // reaches dip_pause one edge later
            @(posedge clk);
            @(negedge clk);
            check_all();
        end
        game_test = 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_all();
        game_test = 1'b0;
    endtask

    task automatic test_random_words();
        osd_pkg::status_t   s;
        osd_pkg::apb_data_t m;
        for (int i = 0; i < 40; i++) begin
            s = {$random(seed), $random(seed)};
            m = $random(seed);
            update_regs(s, m);
            wait_decode();
            check_all();
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        apb_req    = '0;
        game_pause = 1'b0;
        game_test  = 1'b0;
        cur_status = '0;
        cur_mod    = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_state();
        test_readback();
        test_video_modes();
        test_aspect_rotation();
        test_audio_switches();
        test_random_words();

        $display("Simulation passed");
        $finish;
    end

endmodule
